//--- src/afi_pkg.sv
package afi_pkg;

	// ****************************************
	// Memory-side geometry
	// ****************************************

	// Number of DQ pins on the memory interface
	localparam int MEM_DQ_WIDTH = 8;

	// Number of read DQS groups, each strobing its own set of DQ pins
	localparam int READ_DQS_WIDTH = 2;

	// DQ pins strobed by one DQS group
	localparam int DQ_GROUP_WIDTH = MEM_DQ_WIDTH / READ_DQS_WIDTH;

	// ****************************************
	// AFI-side geometry
	// ****************************************

	// Full rate interface with double data rate gives two beats per AFI cycle
	localparam int TIMESLOTS = 2;

	// Read data returned to the controller in one AFI cycle
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * TIMESLOTS;

	// One group's data over all time slots of one AFI cycle
	localparam int GROUP_DATA_WIDTH = DQ_GROUP_WIDTH * TIMESLOTS;

	// ****************************************
	// Data vector types
	// ****************************************

	// Full read data word, either group major or time-slot major depending on the bus
	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;

	// Data of a single DQS group
	// Slot t occupies bits t*DQ_GROUP_WIDTH upwards
	typedef logic [GROUP_DATA_WIDTH-1:0] group_data_t;

	// One flag per DQS group
	typedef logic [READ_DQS_WIDTH-1:0] dqs_mask_t;

endpackage

//--- src/read_path_pkg.sv
package read_path_pkg;

	// ****************************************
	// Read latency selection
	// ****************************************

	// Length of the enable shifter and therefore the largest selectable latency
	localparam int MAX_READ_LATENCY = 16;

	// Width of the latency setting written by the sequencer
	localparam int LATENCY_COUNT_WIDTH = $clog2(MAX_READ_LATENCY);

	// Latency setting in AFI cycles
	typedef logic [LATENCY_COUNT_WIDTH-1:0] latency_count_t;

	// ****************************************
	// Read data FIFO
	// ****************************************

	// Entries held by every per-group FIFO
	localparam int READ_FIFO_DEPTH = 8;

	// Width of the read and write pointers
	localparam int READ_FIFO_ADDR_WIDTH = $clog2(READ_FIFO_DEPTH);

	// Pointer into a group FIFO
	typedef logic [READ_FIFO_ADDR_WIDTH-1:0] fifo_addr_t;

	// ****************************************
	// On-chip termination timing
	// ****************************************

	// Memory read latency in memory clock cycles
	localparam int MEM_T_RL = 6;

	// First and last cycle, counted from the enable, in which termination must stay on
	// Both scale with the memory read latency
	localparam int OCT_ON_DELAY = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

endpackage

//--- src/read_latency_selector.sv
`timescale 1ns/10ps

module read_latency_selector (
	input  logic                         pll_afi_clk,
	input  logic                         reset_n_afi_clk,
	input  logic                         afi_rdata_en_i,
	input  read_path_pkg::latency_count_t latency_i,
	output logic                         read_valid_o
);

	// History of past enables
	// Bit i holds the enable seen i+1 cycles before the current one
	logic [read_path_pkg::MAX_READ_LATENCY-1:0] latency_shifter;

	// Shifter tap that matches the requested latency
	read_path_pkg::latency_count_t tap_sel;

	// ****************************************
	// Enable history
	// ****************************************

	// Every enable bit travels on its own so several reads can be in flight at once
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_shifter <= '0;
		end
		else
		begin
			latency_shifter <=
				{latency_shifter[read_path_pkg::MAX_READ_LATENCY-2:0], afi_rdata_en_i};
		end
	end

	// ****************************************
	// Tap selection
	// ****************************************

	// The output register adds one cycle and the shifter input adds one more
	// So latency N reads tap N-1 to give valid N+1 cycles after the enable
	assign tap_sel = latency_i - read_path_pkg::latency_count_t'(1);

	// The tap is picked every cycle, so a new latency takes effect without a reset
	// Enables already in the shifter then come out at the new delay
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_valid_o <= 1'b0;
		end
		else
		begin
			read_valid_o <= latency_shifter[tap_sel];
		end
	end

endmodule

//--- src/read_group_fifo.sv
`timescale 1ns/10ps

module read_group_fifo (
	input  logic                 pll_afi_clk,
	input  logic                 reset_n_afi_clk,
	input  logic                 fifo_reset_i,
	input  afi_pkg::group_data_t wr_data_i,
	input  logic                 wr_en_i,
	input  logic                 rd_en_i,
	output afi_pkg::group_data_t rd_data_o
);

	// Storage of captured words for one DQS group
	afi_pkg::group_data_t fifo_mem [read_path_pkg::READ_FIFO_DEPTH];

	// Next free entry and oldest unread entry
	read_path_pkg::fifo_addr_t wr_ptr;
	read_path_pkg::fifo_addr_t rd_ptr;

	// Advances a pointer by one entry and wraps after the last one
	function automatic read_path_pkg::fifo_addr_t ptr_inc(input read_path_pkg::fifo_addr_t ptr);
		if (ptr == read_path_pkg::fifo_addr_t'(read_path_pkg::READ_FIFO_DEPTH - 1))
		begin
			return '0;
		end
		return ptr + read_path_pkg::fifo_addr_t'(1);
	endfunction

	// ****************************************
	// Write side
	// ****************************************

	// A word is stored on every edge with the capture strobe high
	// Writing past a full FIFO simply overwrites the oldest entry
	always_ff @(posedge pll_afi_clk)
	begin
		if (wr_en_i)
		begin
			fifo_mem[wr_ptr] <= wr_data_i;
		end
	end

	// The sequencer clear wins over a write in the same cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
		end
		else if (fifo_reset_i)
		begin
			wr_ptr <= '0;
		end
		else if (wr_en_i)
		begin
			wr_ptr <= ptr_inc(wr_ptr);
		end
	end

	// ****************************************
	// Read side
	// ****************************************

	// The oldest entry is always presented, so the data is there in the pop cycle
	assign rd_data_o = fifo_mem[rd_ptr];

	// The pointer moves on the edge that ends the pop cycle
	// Popping an empty FIFO is not blocked and returns whatever sits at the pointer
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rd_ptr <= '0;
		end
		else if (fifo_reset_i)
		begin
			rd_ptr <= '0;
		end
		else if (rd_en_i)
		begin
			rd_ptr <= ptr_inc(rd_ptr);
		end
	end

endmodule

//--- src/oct_control.sv
`timescale 1ns/10ps

module oct_control (
	input  logic               pll_afi_clk,
	input  logic               reset_n_afi_clk,
	input  logic               afi_rdata_en_i,
	output afi_pkg::dqs_mask_t force_oct_off_o
);

	// Delayed copies of the read enable
	// Bit i holds the enable from i+1 cycles ago
	logic [read_path_pkg::OCT_OFF_DELAY-1:0] rdata_en_r;

	// Current enable followed by its delayed copies
	// Bit j holds the enable from j cycles ago
	logic [read_path_pkg::OCT_OFF_DELAY:0] rdata_en_window;

	// High while any enable falls inside the termination window
	logic oct_window;

	// ****************************************
	// Enable delay line
	// ****************************************

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_r <= '0;
		end
		else
		begin
			rdata_en_r <= {rdata_en_r[read_path_pkg::OCT_OFF_DELAY-2:0], afi_rdata_en_i};
		end
	end

	assign rdata_en_window = {rdata_en_r, afi_rdata_en_i};

	// Back to back enables give overlapping windows that merge into one
	assign oct_window =
		|rdata_en_window[read_path_pkg::OCT_OFF_DELAY:read_path_pkg::OCT_ON_DELAY];

	// ****************************************
	// Termination output
	// ****************************************

	// The register adds one cycle, so the window ends up OCT_ON_DELAY+1 to
	// OCT_OFF_DELAY+1 cycles after each enable
	// Out of reset the output starts low and goes high on the first idle edge
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			force_oct_off_o <= '0;
		end
		else
		begin
			force_oct_off_o <= {afi_pkg::READ_DQS_WIDTH{~oct_window}};
		end
	end

endmodule

//--- src/read_datapath.sv
`timescale 1ns/10ps

module read_datapath (
	input  logic                         pll_afi_clk,
	input  logic                         reset_n_afi_clk,
	input  logic                         afi_rdata_en_i,
	input  read_path_pkg::latency_count_t seq_read_latency_counter_i,
	input  afi_pkg::dqs_mask_t           seq_read_fifo_reset_i,
	input  afi_pkg::afi_data_t           ddio_phy_dq_i,
	input  logic                         ddio_valid_i,
	output afi_pkg::afi_data_t           afi_rdata_o,
	output logic                         afi_rdata_valid_o,
	output afi_pkg::afi_data_t           phy_mux_read_fifo_q_o,
	output afi_pkg::dqs_mask_t           force_oct_off_o
);

	// Read valid from the latency selector, also used as the pop of every group FIFO
	logic read_valid;

	// Per-group slices of the captured word and of the FIFO outputs
	afi_pkg::group_data_t group_wr_data [afi_pkg::READ_DQS_WIDTH];
	afi_pkg::group_data_t group_rd_data [afi_pkg::READ_DQS_WIDTH];

	// ****************************************
	// Read latency selection
	// ****************************************

	// The sequencer tunes the latency until valid lines up with the returned data
	read_latency_selector u_read_latency_selector (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_i  (afi_rdata_en_i),
		.latency_i       (seq_read_latency_counter_i),
		.read_valid_o    (read_valid)
	);

	// All groups are popped together so valid is common to the whole bus
	assign afi_rdata_valid_o = read_valid;

	// ****************************************
	// Per-group read FIFOs and data mapping
	// ****************************************

	// The captured bus is group major
	// Group g holds slot t at offset g*GROUP_DATA_WIDTH + t*DQ_GROUP_WIDTH
	for (genvar g = 0; g < afi_pkg::READ_DQS_WIDTH; g++)
	begin : g_group
		assign group_wr_data[g] =
			ddio_phy_dq_i[g*afi_pkg::GROUP_DATA_WIDTH +: afi_pkg::GROUP_DATA_WIDTH];

		// Each group owns its pointers so the sequencer can calibrate it alone
		read_group_fifo u_read_group_fifo (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.fifo_reset_i    (seq_read_fifo_reset_i[g]),
			.wr_data_i       (group_wr_data[g]),
			.wr_en_i         (ddio_valid_i),
			.rd_en_i         (read_valid),
			.rd_data_o       (group_rd_data[g])
		);

		// The sequencer bus keeps the group major order of the capture side
		assign phy_mux_read_fifo_q_o[g*afi_pkg::GROUP_DATA_WIDTH +: afi_pkg::GROUP_DATA_WIDTH] =
			group_rd_data[g];

		// The AFI bus is time-slot major
		// Slot t of group g lands at offset t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH
		for (genvar t = 0; t < afi_pkg::TIMESLOTS; t++)
		begin : g_slot
			assign afi_rdata_o[t*afi_pkg::MEM_DQ_WIDTH + g*afi_pkg::DQ_GROUP_WIDTH +:
				afi_pkg::DQ_GROUP_WIDTH] =
				group_rd_data[g][t*afi_pkg::DQ_GROUP_WIDTH +: afi_pkg::DQ_GROUP_WIDTH];
		end
	end

	// ****************************************
	// On-chip termination control
	// ****************************************

	// Termination is forced off only outside the window around each read burst
	oct_control u_oct_control (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_i  (afi_rdata_en_i),
		.force_oct_off_o (force_oct_off_o)
	);

endmodule

//--- bench/tb_read_datapath.sv
`timescale 1ns/10ps

module tb_read_datapath;

	// Run limit, about four times the length of the full test sequence
	localparam int TIMEOUT_CYCLES = 2000;
	// Cycles to wait for read valid after an enable before giving up
	localparam int VALID_WAIT_LIMIT = 32;
	// Quiet cycles between tests, longer than the enable shifter
	localparam int IDLE_CYCLES = 20;
	// Entries of each software queue in the reference model
	localparam int REF_DEPTH = 64;

	logic                          pll_afi_clk;
	logic                          reset_n_afi_clk;
	logic                          afi_rdata_en;
	read_path_pkg::latency_count_t seq_read_latency_counter;
	afi_pkg::dqs_mask_t            seq_read_fifo_reset;
	afi_pkg::afi_data_t            ddio_phy_dq;
	logic                          ddio_valid;
	afi_pkg::afi_data_t            afi_rdata;
	logic                          afi_rdata_valid;
	afi_pkg::afi_data_t            phy_mux_read_fifo_q;
	afi_pkg::dqs_mask_t            force_oct_off;

	// Cycle count, bumped on every rising edge
	int cyc = 0;
	int check_count = 0;
	int fail_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int test_fail_base = 0;
	string test_name;
	logic [31:0] lfsr_state = 32'h98c9111b;

	// Enable seen in every cycle, indexed by cycle number
	bit en_hist [0:TIMEOUT_CYCLES+1];
	// Per-group software queues of the words written into the FIFOs
	afi_pkg::group_data_t ref_mem [afi_pkg::READ_DQS_WIDTH][REF_DEPTH];
	int ref_wr [afi_pkg::READ_DQS_WIDTH];
	int ref_rd [afi_pkg::READ_DQS_WIDTH];
	// Reset level seen in the previous cycle
	logic reset_prev = 1'b0;

	read_datapath DUT (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en),
		.seq_read_latency_counter_i (seq_read_latency_counter),
		.seq_read_fifo_reset_i      (seq_read_fifo_reset),
		.ddio_phy_dq_i              (ddio_phy_dq),
		.ddio_valid_i               (ddio_valid),
		.afi_rdata_o                (afi_rdata),
		.afi_rdata_valid_o          (afi_rdata_valid),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q),
		.force_oct_off_o            (force_oct_off)
	);

	always #2 pll_afi_clk = ~pll_afi_clk;

	always @(posedge pll_afi_clk)
	begin
		cyc <= cyc + 1;
	end

	// ****************************************
	// Random numbers and reference model
	// ****************************************

	// Galois LFSR, one step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
		end
		return r;
	endfunction

	// Valid in cycle c comes from an enable N+1 cycles earlier
	function automatic logic valid_ref(input int c);
		int k;
		k = c - int'(seq_read_latency_counter) - 1;
		return (k >= 0) && en_hist[k];
	endfunction

	// Termination stays on in cycles k+ON+1 to k+OFF+1 after every enable k
	function automatic afi_pkg::dqs_mask_t oct_ref(input int c);
		int k;
		for (int j = read_path_pkg::OCT_ON_DELAY; j <= read_path_pkg::OCT_OFF_DELAY; j++)
		begin
			k = c - j - 1;
			if (k >= 0 && en_hist[k])
			begin
				return '0;
			end
		end
		return '1;
	endfunction

	// Same window rule for a short enable pattern, i counted from its first bit
	function automatic afi_pkg::dqs_mask_t oct_pattern_ref(input logic [7:0] pattern, input int i);
		for (int p = 0; p < 8; p++)
		begin
			if (pattern[p] && (i - p >= read_path_pkg::OCT_ON_DELAY + 1) &&
				(i - p <= read_path_pkg::OCT_OFF_DELAY + 1))
			begin
				return '0;
			end
		end
		return '1;
	endfunction

	// Group major word to the time-slot major AFI layout
	function automatic afi_pkg::afi_data_t to_slot_major(input afi_pkg::afi_data_t group_major);
		afi_pkg::afi_data_t res;
		res = '0;
		for (int g = 0; g < afi_pkg::READ_DQS_WIDTH; g++)
		begin
			for (int t = 0; t < afi_pkg::TIMESLOTS; t++)
			begin
				res[t*afi_pkg::MEM_DQ_WIDTH + g*afi_pkg::DQ_GROUP_WIDTH +: afi_pkg::DQ_GROUP_WIDTH] =
					group_major[g*afi_pkg::GROUP_DATA_WIDTH + t*afi_pkg::DQ_GROUP_WIDTH +:
					afi_pkg::DQ_GROUP_WIDTH];
			end
		end
		return res;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			fail_count++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h in cycle %0d",
				name, got, expected, cyc);
		end
	endtask

	// ****************************************
	// Cycle by cycle comparison
	// ****************************************

	// Outputs and inputs are all stable at the falling edge
	always @(negedge pll_afi_clk)
	begin : compare
		logic exp_valid;
		afi_pkg::dqs_mask_t exp_oct;
		afi_pkg::afi_data_t group_major;
		bit all_ready;
		en_hist[cyc] = afi_rdata_en;
		// Nothing but reset values until one edge has passed with reset released
		if (!reset_n_afi_clk || !reset_prev)
		begin
			exp_valid = 1'b0;
			exp_oct = '0;
		end
		else
		begin
			exp_valid = valid_ref(cyc);
			exp_oct = oct_ref(cyc);
		end
		check_value("afi_rdata_valid_o", afi_rdata_valid, exp_valid);
		check_value("force_oct_off_o", force_oct_off, exp_oct);
		if (exp_valid)
		begin
			all_ready = 1'b1;
			group_major = '0;
			for (int g = 0; g < afi_pkg::READ_DQS_WIDTH; g++)
			begin
				if (ref_wr[g] == ref_rd[g])
				begin
					all_ready = 1'b0;
				end
				group_major[g*afi_pkg::GROUP_DATA_WIDTH +: afi_pkg::GROUP_DATA_WIDTH] =
					ref_mem[g][ref_rd[g] % REF_DEPTH];
			end
			// A pop on an empty FIFO returns stale data that is not checked
			if (all_ready)
			begin
				check_value("afi_rdata_o", afi_rdata, to_slot_major(group_major));
				check_value("phy_mux_read_fifo_q_o", phy_mux_read_fifo_q, group_major);
			end
			for (int g = 0; g < afi_pkg::READ_DQS_WIDTH; g++)
			begin
				if (ref_wr[g] != ref_rd[g])
				begin
					ref_rd[g]++;
				end
			end
		end
		// A group clear drops everything queued for that group, including this write
		for (int g = 0; g < afi_pkg::READ_DQS_WIDTH; g++)
		begin
			if (seq_read_fifo_reset[g])
			begin
				ref_rd[g] = ref_wr[g];
			end
			else if (ddio_valid)
			begin
				ref_mem[g][ref_wr[g] % REF_DEPTH] =
					ddio_phy_dq[g*afi_pkg::GROUP_DATA_WIDTH +: afi_pkg::GROUP_DATA_WIDTH];
				ref_wr[g]++;
			end
		end
		reset_prev = reset_n_afi_clk;
	end

	// ****************************************
	// Stimulus tasks
	// ****************************************

	task automatic begin_test(input string name);
		test_name = name;
		test_fail_base = fail_count;
	endtask

	task automatic end_test();
		if (fail_count == test_fail_base)
		begin
			tests_passed++;
			$display("Test %s: passed", test_name);
		end
		else
		begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", test_name, fail_count - test_fail_base);
		end
	endtask

	task automatic idle();
		repeat (IDLE_CYCLES) @(posedge pll_afi_clk);
	endtask

	task automatic set_latency(input read_path_pkg::latency_count_t n);
		@(posedge pll_afi_clk);
		seq_read_latency_counter <= n;
	endtask

	task automatic clear_fifos(input afi_pkg::dqs_mask_t mask);
		@(posedge pll_afi_clk);
		seq_read_fifo_reset <= mask;
		@(posedge pll_afi_clk);
		seq_read_fifo_reset <= '0;
	endtask

	task automatic write_words(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge pll_afi_clk);
			ddio_valid <= 1'b1;
			ddio_phy_dq <= afi_pkg::afi_data_t'(rand_bits(afi_pkg::AFI_DATA_WIDTH));
		end
		@(posedge pll_afi_clk);
		ddio_valid <= 1'b0;
	endtask

	// Sends a burst of enables and measures when valid arrives and how long it lasts
	task automatic issue_reads(input int burst);
		int delay;
		int run;
		delay = 0;
		run = 0;
		@(posedge pll_afi_clk);
		afi_rdata_en <= 1'b1;
		fork
			begin
				repeat (burst) @(posedge pll_afi_clk);
				afi_rdata_en <= 1'b0;
			end
			begin
				@(negedge pll_afi_clk);
				while (!afi_rdata_valid && delay < VALID_WAIT_LIMIT)
				begin
					@(negedge pll_afi_clk);
					delay++;
				end
				while (afi_rdata_valid && run <= burst)
				begin
					run++;
					@(negedge pll_afi_clk);
				end
			end
		join
		if (delay >= VALID_WAIT_LIMIT)
		begin
			fail_count++;
			$display("Read valid did not arrive within %0d cycles of the enable", delay);
		end
		else
		begin
			check_value("read latency", delay, int'(seq_read_latency_counter) + 1);
			check_value("valid burst length", run, burst);
		end
		idle();
	endtask

	// Drives an enable pattern and checks the termination output over the next 16 cycles
	task automatic run_oct_pattern(input logic [7:0] pattern);
		@(posedge pll_afi_clk);
		afi_rdata_en <= pattern[0];
		fork
			begin
				for (int p = 1; p < 8; p++)
				begin
					@(posedge pll_afi_clk);
					afi_rdata_en <= pattern[p];
				end
				@(posedge pll_afi_clk);
				afi_rdata_en <= 1'b0;
			end
			begin
				for (int i = 0; i < 16; i++)
				begin
					@(negedge pll_afi_clk);
					check_value("force_oct_off_o window", force_oct_off, oct_pattern_ref(pattern, i));
				end
			end
		join
		idle();
	endtask

	// ****************************************
	// Test sequence
	// ****************************************

	initial
	begin
		wait (cyc >= TIMEOUT_CYCLES);
		$display("Run timed out after %0d cycles before the tests finished", cyc);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		pll_afi_clk = 1'b0;
		reset_n_afi_clk = 1'b0;
		afi_rdata_en = 1'b0;
		seq_read_latency_counter = read_path_pkg::latency_count_t'(1);
		seq_read_fifo_reset = '0;
		ddio_phy_dq = '0;
		ddio_valid = 1'b0;

		begin_test("reset state");
		repeat (7) @(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		check_value("afi_rdata_valid_o in reset", afi_rdata_valid, 1'b0);
		check_value("force_oct_off_o in reset", force_oct_off, 0);
		@(posedge pll_afi_clk);
		reset_n_afi_clk <= 1'b1;
		@(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		check_value("force_oct_off_o after reset", force_oct_off, afi_pkg::dqs_mask_t'('1));
		check_value("afi_rdata_valid_o after reset", afi_rdata_valid, 1'b0);
		idle();
		end_test();

		begin_test("latency selection");
		for (int i = 0; i < 4; i++)
		begin
			set_latency(read_path_pkg::latency_count_t'(rand_bits(4) % 14 + 1));
			issue_reads(1);
			issue_reads(int'(rand_bits(3)) + 1);
		end
		end_test();

		begin_test("data ordering");
		for (int i = 0; i < 3; i++)
		begin
			int burst;
			burst = int'(rand_bits(3)) + 1;
			clear_fifos('1);
			set_latency(read_path_pkg::latency_count_t'(rand_bits(4) % 14 + 1));
			write_words(burst);
			issue_reads(burst);
		end
		end_test();

		begin_test("termination window");
		run_oct_pattern(8'b0000_0001);
		run_oct_pattern(8'b0000_0011);
		run_oct_pattern(8'b0000_1001);
		end_test();

		// Group 1 keeps its first words while group 0 starts over
		begin_test("per-group FIFO reset");
		clear_fifos('1);
		write_words(3);
		clear_fifos(afi_pkg::dqs_mask_t'(1));
		write_words(2);
		issue_reads(2);
		end_test();

		$display("Tests passed: %0d, tests failed: %0d, checks: %0d, errors: %0d",
			tests_passed, tests_failed, check_count, fail_count);
		if (tests_failed == 0 && fail_count == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
src/afi_pkg.sv
src/read_path_pkg.sv
src/read_latency_selector.sv
src/read_group_fifo.sv
src/oct_control.sv
src/read_datapath.sv
bench/tb_read_datapath.sv
